// File: design/cpuTypesPkg.sv
package cpuTypesPkg;

   localparam int wordWidth = 32;
   localparam int regAddrWidth = 5;
   localparam int opWidth = 6;
   localparam int immWidth = 16;
   localparam int jAddrWidth = 26;

   // primary opcodes
   localparam logic [opWidth-1:0] opRtype = 6'h00;
   localparam logic [opWidth-1:0] opJ = 6'h02;
   localparam logic [opWidth-1:0] opJal = 6'h03;
   localparam logic [opWidth-1:0] opBeq = 6'h04;
   localparam logic [opWidth-1:0] opBne = 6'h05;
   localparam logic [opWidth-1:0] opAddiu = 6'h09;
   localparam logic [opWidth-1:0] opSlti = 6'h0a;
   localparam logic [opWidth-1:0] opAndi = 6'h0c;
   localparam logic [opWidth-1:0] opOri = 6'h0d;
   localparam logic [opWidth-1:0] opXori = 6'h0e;
   localparam logic [opWidth-1:0] opLui = 6'h0f;
   localparam logic [opWidth-1:0] opLw = 6'h23;
   localparam logic [opWidth-1:0] opSw = 6'h2b;
   localparam logic [opWidth-1:0] opHalt = 6'h3f;

   // funct codes for R-type only
   localparam logic [opWidth-1:0] fnSll = 6'h00;
   localparam logic [opWidth-1:0] fnSrl = 6'h02;
   localparam logic [opWidth-1:0] fnJr = 6'h08;
   localparam logic [opWidth-1:0] fnAddu = 6'h21;
   localparam logic [opWidth-1:0] fnSubu = 6'h23;
   localparam logic [opWidth-1:0] fnAnd = 6'h24;
   localparam logic [opWidth-1:0] fnOr = 6'h25;
   localparam logic [opWidth-1:0] fnXor = 6'h26;
   localparam logic [opWidth-1:0] fnNor = 6'h27;
   localparam logic [opWidth-1:0] fnSlt = 6'h2a;
   localparam logic [opWidth-1:0] fnSltu = 6'h2b;

   // the bubble relies on aluSll being zero
   typedef enum logic [3:0] {
      aluSll,
      aluSrl,
      aluAdd,
      aluSub,
      aluAnd,
      aluOr,
      aluXor,
      aluNor,
      aluSlt,
      aluSltu,
      aluLui
   } aluOpT;

   typedef struct packed {
      logic [opWidth-1:0] opcode;
      logic [regAddrWidth-1:0] rs;
      logic [regAddrWidth-1:0] rt;
      logic [regAddrWidth-1:0] rd;
      logic [regAddrWidth-1:0] shamt;
      logic [opWidth-1:0] funct;
   } rTypeT;

   typedef struct packed {
      logic [opWidth-1:0] opcode;
      logic [regAddrWidth-1:0] rs;
      logic [regAddrWidth-1:0] rt;
      logic [immWidth-1:0] imm;
   } iTypeT;

   typedef struct packed {
      logic [opWidth-1:0] opcode;
      logic [jAddrWidth-1:0] addr;
   } jTypeT;

   typedef union packed {
      rTypeT rType;
      iTypeT iType;
      jTypeT jType;
   } instrWordT;

endpackage

// File: design/controlUnit.sv
`timescale 1ns/10ps

module controlUnit
(
   input cpuTypesPkg::instrWordT instr,
   output logic regDst,
   output logic aluSrc,
   output logic extSign,
   output logic memToReg,
   output logic regWen,
   output logic memRead,
   output logic memWrite,
   output logic branchEq,
   output logic branchNe,
   output logic jump,
   output logic jumpReg,
   output logic jal,
   output logic lui,
   output logic shift,
   output logic halt,
   output cpuTypesPkg::aluOpT aluOp
);

   logic rdNonZero;
   logic rtNonZero;

   // writes to register 0 are dropped here so later stages never see them
   assign rdNonZero = instr.rType.rd != '0;
   assign rtNonZero = instr.iType.rt != '0;

   always_comb
   begin
      regDst = 1'b0;
      aluSrc = 1'b0;
      extSign = 1'b0;
      memToReg = 1'b0;
      regWen = 1'b0;
      memRead = 1'b0;
      memWrite = 1'b0;
      branchEq = 1'b0;
      branchNe = 1'b0;
      jump = 1'b0;
      jumpReg = 1'b0;
      jal = 1'b0;
      lui = 1'b0;
      shift = 1'b0;
      halt = 1'b0;
      aluOp = cpuTypesPkg::aluSll;

      case (instr.rType.opcode)
         cpuTypesPkg::opRtype:
         begin
            regDst = 1'b1;
            regWen = rdNonZero;
            case (instr.rType.funct)
               cpuTypesPkg::fnSll: shift = 1'b1;
               cpuTypesPkg::fnSrl:
               begin
                  shift = 1'b1;
                  aluOp = cpuTypesPkg::aluSrl;
               end
               cpuTypesPkg::fnAddu: aluOp = cpuTypesPkg::aluAdd;
               cpuTypesPkg::fnSubu: aluOp = cpuTypesPkg::aluSub;
               cpuTypesPkg::fnAnd: aluOp = cpuTypesPkg::aluAnd;
               cpuTypesPkg::fnOr: aluOp = cpuTypesPkg::aluOr;
               cpuTypesPkg::fnXor: aluOp = cpuTypesPkg::aluXor;
               cpuTypesPkg::fnNor: aluOp = cpuTypesPkg::aluNor;
               cpuTypesPkg::fnSlt: aluOp = cpuTypesPkg::aluSlt;
               cpuTypesPkg::fnSltu: aluOp = cpuTypesPkg::aluSltu;
               cpuTypesPkg::fnJr:
               begin
                  regDst = 1'b0;
                  regWen = 1'b0;
                  jumpReg = 1'b1;
               end
               // unknown funct is a bubble
               default:
               begin
                  regDst = 1'b0;
                  regWen = 1'b0;
               end
            endcase
         end
         cpuTypesPkg::opAddiu,
         cpuTypesPkg::opSlti,
         cpuTypesPkg::opAndi,
         cpuTypesPkg::opOri,
         cpuTypesPkg::opXori,
         cpuTypesPkg::opLui,
         cpuTypesPkg::opLw:
         begin
            aluSrc = 1'b1;
            regWen = rtNonZero;
            case (instr.iType.opcode)
               cpuTypesPkg::opAddiu:
               begin
                  extSign = 1'b1;
                  aluOp = cpuTypesPkg::aluAdd;
               end
               cpuTypesPkg::opSlti:
               begin
                  extSign = 1'b1;
                  aluOp = cpuTypesPkg::aluSlt;
               end
               cpuTypesPkg::opAndi: aluOp = cpuTypesPkg::aluAnd;
               cpuTypesPkg::opOri: aluOp = cpuTypesPkg::aluOr;
               cpuTypesPkg::opXori: aluOp = cpuTypesPkg::aluXor;
               cpuTypesPkg::opLui:
               begin
                  lui = 1'b1;
                  aluOp = cpuTypesPkg::aluLui;
               end
               default:
               begin
                  // load word
                  extSign = 1'b1;
                  memRead = 1'b1;
                  memToReg = 1'b1;
                  aluOp = cpuTypesPkg::aluAdd;
               end
            endcase
         end
         cpuTypesPkg::opSw:
         begin
            aluSrc = 1'b1;
            extSign = 1'b1;
            memWrite = 1'b1;
            aluOp = cpuTypesPkg::aluAdd;
         end
         cpuTypesPkg::opBeq,
         cpuTypesPkg::opBne:
         begin
            extSign = 1'b1;
            branchEq = instr.iType.opcode == cpuTypesPkg::opBeq;
            branchNe = instr.iType.opcode == cpuTypesPkg::opBne;
            aluOp = cpuTypesPkg::aluSub;
         end
         cpuTypesPkg::opJ: jump = 1'b1;
         cpuTypesPkg::opJal:
         begin
            jump = 1'b1;
            jal = 1'b1;
            regWen = 1'b1;
         end
         cpuTypesPkg::opHalt: halt = 1'b1;
         default: ;
      endcase
   end

endmodule

// File: design/registerFile.sv
`timescale 1ns/10ps

module registerFile
(
   input logic CLK,
   input logic nRST,
   input logic [cpuTypesPkg::regAddrWidth-1:0] rsAddr,
   input logic [cpuTypesPkg::regAddrWidth-1:0] rtAddr,
   input logic [cpuTypesPkg::regAddrWidth-1:0] wbReg,
   input logic wbWen,
   input logic [cpuTypesPkg::wordWidth-1:0] wbData,
   output logic [cpuTypesPkg::wordWidth-1:0] rsData,
   output logic [cpuTypesPkg::wordWidth-1:0] rtData
);

   logic [cpuTypesPkg::wordWidth-1:0] regs [2**cpuTypesPkg::regAddrWidth];

   // entry 0 is never written, so it keeps its reset value
   always_ff @(posedge CLK, negedge nRST)
   begin
      if (!nRST)
      begin
         for (int i = 0; i < 2**cpuTypesPkg::regAddrWidth; i++)
            regs[i] <= '0;
      end
      else if (wbWen && wbReg != '0)
         regs[wbReg] <= wbData;
   end

   // same-cycle write-back is forwarded to the read ports
   assign rsData = (rsAddr == '0) ? '0 :
                   (wbWen && wbReg == rsAddr) ? wbData : regs[rsAddr];
   assign rtData = (rtAddr == '0) ? '0 :
                   (wbWen && wbReg == rtAddr) ? wbData : regs[rtAddr];

endmodule

// File: design/idExRegister.sv
`timescale 1ns/10ps

module idExRegister
(
   input logic CLK,
   input logic nRST,
   input logic advance,
   input logic flush,
   input logic regDst,
   input logic aluSrc,
   input logic extSign,
   input logic memToReg,
   input logic regWen,
   input logic memRead,
   input logic memWrite,
   input logic branchEq,
   input logic branchNe,
   input logic jump,
   input logic jumpReg,
   input logic jal,
   input logic lui,
   input logic shift,
   input logic halt,
   input cpuTypesPkg::aluOpT aluOp,
   input logic [cpuTypesPkg::wordWidth-1:0] rsDataIn,
   input logic [cpuTypesPkg::wordWidth-1:0] rtDataIn,
   input cpuTypesPkg::instrWordT instr,
   input logic [cpuTypesPkg::wordWidth-1:0] pcNextIn,
   output logic exRegDst,
   output logic exAluSrc,
   output logic exExtSign,
   output logic exMemToReg,
   output logic exRegWen,
   output logic exMemRead,
   output logic exMemWrite,
   output logic exBranchEq,
   output logic exBranchNe,
   output logic exJump,
   output logic exJumpReg,
   output logic exJal,
   output logic exLui,
   output logic exShift,
   output logic exHalt,
   output cpuTypesPkg::aluOpT exAluOp,
   output logic [cpuTypesPkg::wordWidth-1:0] exRsData,
   output logic [cpuTypesPkg::wordWidth-1:0] exRtData,
   output logic [cpuTypesPkg::regAddrWidth-1:0] exRd,
   output logic [cpuTypesPkg::regAddrWidth-1:0] exRt,
   output logic [cpuTypesPkg::regAddrWidth-1:0] exShamt,
   output logic [cpuTypesPkg::immWidth-1:0] exImm,
   output logic [cpuTypesPkg::jAddrWidth-1:0] exJumpAddr,
   output logic [cpuTypesPkg::wordWidth-1:0] exPcNext
);

   always_ff @(posedge CLK, negedge nRST)
   begin
      if (!nRST)
      begin
         exRegDst <= 1'b0;
         exAluSrc <= 1'b0;
         exExtSign <= 1'b0;
         exMemToReg <= 1'b0;
         exRegWen <= 1'b0;
         exMemRead <= 1'b0;
         exMemWrite <= 1'b0;
         exBranchEq <= 1'b0;
         exBranchNe <= 1'b0;
         exJump <= 1'b0;
         exJumpReg <= 1'b0;
         exJal <= 1'b0;
         exLui <= 1'b0;
         exShift <= 1'b0;
         exHalt <= 1'b0;
         exAluOp <= cpuTypesPkg::aluSll;
         exRsData <= '0;
         exRtData <= '0;
         exRd <= '0;
         exRt <= '0;
         exShamt <= '0;
         exImm <= '0;
         exJumpAddr <= '0;
         exPcNext <= '0;
      end
      // flush loads the same bubble as reset and a low advance holds everything
      else if (advance)
      begin
         exRegDst <= flush ? 1'b0 : regDst;
         exAluSrc <= flush ? 1'b0 : aluSrc;
         exExtSign <= flush ? 1'b0 : extSign;
         exMemToReg <= flush ? 1'b0 : memToReg;
         exRegWen <= flush ? 1'b0 : regWen;
         exMemRead <= flush ? 1'b0 : memRead;
         exMemWrite <= flush ? 1'b0 : memWrite;
         exBranchEq <= flush ? 1'b0 : branchEq;
         exBranchNe <= flush ? 1'b0 : branchNe;
         exJump <= flush ? 1'b0 : jump;
         exJumpReg <= flush ? 1'b0 : jumpReg;
         exJal <= flush ? 1'b0 : jal;
         exLui <= flush ? 1'b0 : lui;
         exShift <= flush ? 1'b0 : shift;
         exHalt <= flush ? 1'b0 : halt;
         exAluOp <= flush ? cpuTypesPkg::aluSll : aluOp;
         exRsData <= flush ? '0 : rsDataIn;
         exRtData <= flush ? '0 : rtDataIn;
         exRd <= flush ? '0 : instr.rType.rd;
         exRt <= flush ? '0 : instr.iType.rt;
         exShamt <= flush ? '0 : instr.rType.shamt;
         exImm <= flush ? '0 : instr.iType.imm;
         exJumpAddr <= flush ? '0 : instr.jType.addr;
         exPcNext <= flush ? '0 : pcNextIn;
      end
   end

endmodule

// File: design/executeStage.sv
`timescale 1ns/10ps

module executeStage
(
   input logic exRegDst,
   input logic exAluSrc,
   input logic exExtSign,
   input logic exMemToReg,
   input logic exRegWen,
   input logic exMemRead,
   input logic exMemWrite,
   input logic exBranchEq,
   input logic exBranchNe,
   input logic exJump,
   input logic exJumpReg,
   input logic exJal,
   input logic exLui,
   input logic exShift,
   input logic exHalt,
   input cpuTypesPkg::aluOpT exAluOp,
   input logic [cpuTypesPkg::wordWidth-1:0] exRsData,
   input logic [cpuTypesPkg::wordWidth-1:0] exRtData,
   input logic [cpuTypesPkg::regAddrWidth-1:0] exRd,
   input logic [cpuTypesPkg::regAddrWidth-1:0] exRt,
   input logic [cpuTypesPkg::regAddrWidth-1:0] exShamt,
   input logic [cpuTypesPkg::immWidth-1:0] exImm,
   input logic [cpuTypesPkg::jAddrWidth-1:0] exJumpAddr,
   input logic [cpuTypesPkg::wordWidth-1:0] exPcNext,
   output logic [cpuTypesPkg::wordWidth-1:0] aluResult,
   output logic [cpuTypesPkg::wordWidth-1:0] storeData,
   output logic [cpuTypesPkg::wordWidth-1:0] branchTarget,
   output logic [cpuTypesPkg::regAddrWidth-1:0] writeReg,
   output logic regWen,
   output logic memRead,
   output logic memWrite,
   output logic memToReg,
   output logic halt,
   output logic branchTaken
);

   logic [cpuTypesPkg::wordWidth-1:0] extImm;
   logic [cpuTypesPkg::wordWidth-1:0] branchOffset;
   logic [cpuTypesPkg::wordWidth-1:0] opA;
   logic [cpuTypesPkg::wordWidth-1:0] opB;
   logic [cpuTypesPkg::wordWidth-1:0] aluOut;
   logic operandsEqual;

   always_comb
   begin
      if (exLui)
         extImm = {exImm, {(cpuTypesPkg::wordWidth-cpuTypesPkg::immWidth){1'b0}}};
      else if (exExtSign)
         extImm = {{(cpuTypesPkg::wordWidth-cpuTypesPkg::immWidth){
                   exImm[cpuTypesPkg::immWidth-1]}}, exImm};
      else
         extImm = {{(cpuTypesPkg::wordWidth-cpuTypesPkg::immWidth){1'b0}}, exImm};
   end

   // shifts take rt as the value and shamt as the amount
   assign opA = exShift ? exRtData : exRsData;
   assign opB = exAluSrc ? extImm : exRtData;

   always_comb
   begin
      case (exAluOp)
         cpuTypesPkg::aluSll: aluOut = opA << exShamt;
         cpuTypesPkg::aluSrl: aluOut = opA >> exShamt;
         cpuTypesPkg::aluAdd: aluOut = opA + opB;
         cpuTypesPkg::aluSub: aluOut = opA - opB;
         cpuTypesPkg::aluAnd: aluOut = opA & opB;
         cpuTypesPkg::aluOr: aluOut = opA | opB;
         cpuTypesPkg::aluXor: aluOut = opA ^ opB;
         cpuTypesPkg::aluNor: aluOut = ~(opA | opB);
         cpuTypesPkg::aluSlt: aluOut = ($signed(opA) < $signed(opB)) ? 1 : 0;
         cpuTypesPkg::aluSltu: aluOut = (opA < opB) ? 1 : 0;
         cpuTypesPkg::aluLui: aluOut = opB;
         default: aluOut = '0;
      endcase
   end

   // link value for JAL replaces the ALU output
   assign aluResult = exJal ? exPcNext : aluOut;
   assign storeData = exRtData;
   assign writeReg = exJal ? '1 : (exRegDst ? exRd : exRt);

   assign operandsEqual = exRsData == exRtData;
   assign branchTaken = (exBranchEq && operandsEqual) || (exBranchNe && !operandsEqual) ||
                        exJump || exJumpReg;

   // branch offset is always sign-extended whatever extSign says
   assign branchOffset = {{(cpuTypesPkg::wordWidth-cpuTypesPkg::immWidth-2){
                          exImm[cpuTypesPkg::immWidth-1]}}, exImm, 2'b00};

   always_comb
   begin
      if (exJumpReg)
         branchTarget = exRsData;
      else if (exJump)
         branchTarget = {exPcNext[cpuTypesPkg::wordWidth-1 -: 4], exJumpAddr, 2'b00};
      else
         branchTarget = exPcNext + branchOffset;
   end

   assign regWen = exRegWen;
   assign memRead = exMemRead;
   assign memWrite = exMemWrite;
   assign memToReg = exMemToReg;
   assign halt = exHalt;

endmodule

// File: design/decodeExecute.sv
`timescale 1ns/10ps

module decodeExecute
(
   input logic CLK,
   input logic nRST,
   input cpuTypesPkg::instrWordT instr,
   input logic [cpuTypesPkg::wordWidth-1:0] pcNext,
   input logic advance,
   input logic flush,
   input logic wbWen,
   input logic [cpuTypesPkg::regAddrWidth-1:0] wbReg,
   input logic [cpuTypesPkg::wordWidth-1:0] wbData,
   output logic [cpuTypesPkg::wordWidth-1:0] aluResult,
   output logic [cpuTypesPkg::wordWidth-1:0] storeData,
   output logic [cpuTypesPkg::wordWidth-1:0] branchTarget,
   output logic [cpuTypesPkg::regAddrWidth-1:0] writeReg,
   output logic regWen,
   output logic memRead,
   output logic memWrite,
   output logic memToReg,
   output logic halt,
   output logic branchTaken
);

   // decode side
   logic idRegDst, idAluSrc, idExtSign, idMemToReg, idRegWen, idMemRead, idMemWrite;
   logic idBranchEq, idBranchNe, idJump, idJumpReg, idJal, idLui, idShift, idHalt;
   cpuTypesPkg::aluOpT idAluOp;
   logic [cpuTypesPkg::wordWidth-1:0] rsData;
   logic [cpuTypesPkg::wordWidth-1:0] rtData;

   // execute side
   logic exRegDst, exAluSrc, exExtSign, exMemToReg, exRegWen, exMemRead, exMemWrite;
   logic exBranchEq, exBranchNe, exJump, exJumpReg, exJal, exLui, exShift, exHalt;
   cpuTypesPkg::aluOpT exAluOp;
   logic [cpuTypesPkg::wordWidth-1:0] exRsData;
   logic [cpuTypesPkg::wordWidth-1:0] exRtData;
   logic [cpuTypesPkg::regAddrWidth-1:0] exRd;
   logic [cpuTypesPkg::regAddrWidth-1:0] exRt;
   logic [cpuTypesPkg::regAddrWidth-1:0] exShamt;
   logic [cpuTypesPkg::immWidth-1:0] exImm;
   logic [cpuTypesPkg::jAddrWidth-1:0] exJumpAddr;
   logic [cpuTypesPkg::wordWidth-1:0] exPcNext;

   controlUnit controlUnit_i
   (
      .instr(instr),
      .regDst(idRegDst), .aluSrc(idAluSrc), .extSign(idExtSign), .memToReg(idMemToReg),
      .regWen(idRegWen), .memRead(idMemRead), .memWrite(idMemWrite),
      .branchEq(idBranchEq), .branchNe(idBranchNe), .jump(idJump), .jumpReg(idJumpReg),
      .jal(idJal), .lui(idLui), .shift(idShift), .halt(idHalt), .aluOp(idAluOp)
   );

   registerFile registerFile_i
   (
      .CLK(CLK), .nRST(nRST),
      .rsAddr(instr.rType.rs), .rtAddr(instr.rType.rt),
      .wbReg(wbReg), .wbWen(wbWen), .wbData(wbData),
      .rsData(rsData), .rtData(rtData)
   );

   idExRegister idExRegister_i
   (
      .CLK(CLK), .nRST(nRST), .advance(advance), .flush(flush),
      .regDst(idRegDst), .aluSrc(idAluSrc), .extSign(idExtSign), .memToReg(idMemToReg),
      .regWen(idRegWen), .memRead(idMemRead), .memWrite(idMemWrite),
      .branchEq(idBranchEq), .branchNe(idBranchNe), .jump(idJump), .jumpReg(idJumpReg),
      .jal(idJal), .lui(idLui), .shift(idShift), .halt(idHalt), .aluOp(idAluOp),
      .rsDataIn(rsData), .rtDataIn(rtData), .instr(instr), .pcNextIn(pcNext),
      .exRegDst(exRegDst), .exAluSrc(exAluSrc), .exExtSign(exExtSign),
      .exMemToReg(exMemToReg), .exRegWen(exRegWen), .exMemRead(exMemRead),
      .exMemWrite(exMemWrite), .exBranchEq(exBranchEq), .exBranchNe(exBranchNe),
      .exJump(exJump), .exJumpReg(exJumpReg), .exJal(exJal), .exLui(exLui),
      .exShift(exShift), .exHalt(exHalt), .exAluOp(exAluOp),
      .exRsData(exRsData), .exRtData(exRtData), .exRd(exRd), .exRt(exRt),
      .exShamt(exShamt), .exImm(exImm), .exJumpAddr(exJumpAddr), .exPcNext(exPcNext)
   );

   executeStage executeStage_i
   (
      .exRegDst(exRegDst), .exAluSrc(exAluSrc), .exExtSign(exExtSign),
      .exMemToReg(exMemToReg), .exRegWen(exRegWen), .exMemRead(exMemRead),
      .exMemWrite(exMemWrite), .exBranchEq(exBranchEq), .exBranchNe(exBranchNe),
      .exJump(exJump), .exJumpReg(exJumpReg), .exJal(exJal), .exLui(exLui),
      .exShift(exShift), .exHalt(exHalt), .exAluOp(exAluOp),
      .exRsData(exRsData), .exRtData(exRtData), .exRd(exRd), .exRt(exRt),
      .exShamt(exShamt), .exImm(exImm), .exJumpAddr(exJumpAddr), .exPcNext(exPcNext),
      .aluResult(aluResult), .storeData(storeData), .branchTarget(branchTarget),
      .writeReg(writeReg), .regWen(regWen), .memRead(memRead), .memWrite(memWrite),
      .memToReg(memToReg), .halt(halt), .branchTaken(branchTaken)
   );

endmodule

// File: dv/decodeExecuteModel.svh
`ifndef DECODE_EXECUTE_MODEL_SVH
`define DECODE_EXECUTE_MODEL_SVH

typedef struct packed {
   logic [cpuTypesPkg::wordWidth-1:0] aluResult;
   logic [cpuTypesPkg::wordWidth-1:0] storeData;
   logic [cpuTypesPkg::wordWidth-1:0] branchTarget;
   logic [cpuTypesPkg::regAddrWidth-1:0] writeReg;
   logic regWen;
   logic memRead;
   logic memWrite;
   logic memToReg;
   logic halt;
   logic branchTaken;
   logic careAlu;
   logic careTarget;
} expectT;

logic [cpuTypesPkg::wordWidth-1:0] modelRegs [32];

// latched copy of the instruction in execute
// mValid low means bubble
logic mValid;
cpuTypesPkg::instrWordT mInstr;
logic [cpuTypesPkg::wordWidth-1:0] mRs;
logic [cpuTypesPkg::wordWidth-1:0] mRt;
logic [cpuTypesPkg::wordWidth-1:0] mPc;

task automatic resetModel();
   for (int i = 0; i < 32; i++)
      modelRegs[i] = '0;
   mValid = 1'b0;
   mInstr = '0;
   mRs = '0;
   mRt = '0;
   mPc = '0;
endtask

function automatic logic [31:0] readReg(input logic [4:0] addr, input logic wen,
                                        input logic [4:0] wreg, input logic [31:0] wdata);
   if (addr == 5'd0)
      return 32'd0;
   // same-cycle write-back wins over the stored value
   if (wen && wreg == addr)
      return wdata;
   return modelRegs[addr];
endfunction

// one rising edge latches the decode side before the write-back lands
task automatic stepModel(input cpuTypesPkg::instrWordT w, input logic [31:0] pc,
                         input logic adv, input logic fl, input logic wen,
                         input logic [4:0] wreg, input logic [31:0] wdata);
   if (adv && fl)
   begin
      mValid = 1'b0;
      mInstr = '0;
      mRs = '0;
      mRt = '0;
      mPc = '0;
   end
   else if (adv)
   begin
      mValid = 1'b1;
      mInstr = w;
      mRs = readReg(w.rType.rs, wen, wreg, wdata);
      mRt = readReg(w.rType.rt, wen, wreg, wdata);
      mPc = pc;
   end
   if (wen && wreg != 5'd0)
      modelRegs[wreg] = wdata;
endtask

function automatic expectT predict();
   expectT e;
   logic [31:0] sImm;
   logic [31:0] zImm;
   logic [5:0] op;
   e = '0;
   e.careAlu = 1'b1;
   e.careTarget = 1'b1;
   // a bubble shows all zeros including the shift of zero operands
   if (!mValid)
      return e;
   op = mInstr.rType.opcode;
   sImm = {{16{mInstr.iType.imm[15]}}, mInstr.iType.imm};
   zImm = {16'h0000, mInstr.iType.imm};
   e.storeData = mRt;
   e.writeReg = mInstr.iType.rt;
   e.careTarget = 1'b0;
   if (op == cpuTypesPkg::opAddiu || op == cpuTypesPkg::opSlti || op == cpuTypesPkg::opAndi ||
       op == cpuTypesPkg::opOri || op == cpuTypesPkg::opXori || op == cpuTypesPkg::opLui ||
       op == cpuTypesPkg::opLw)
      e.regWen = mInstr.iType.rt != 5'd0;
   case (op)
      cpuTypesPkg::opRtype:
      begin
         if (mInstr.rType.funct == cpuTypesPkg::fnJr)
         begin
            e.careAlu = 1'b0;
            e.careTarget = 1'b1;
            e.branchTaken = 1'b1;
            e.branchTarget = mRs;
         end
         else
         begin
            e.writeReg = mInstr.rType.rd;
            e.regWen = mInstr.rType.rd != 5'd0;
            case (mInstr.rType.funct)
               cpuTypesPkg::fnAddu: e.aluResult = mRs + mRt;
               cpuTypesPkg::fnSubu: e.aluResult = mRs - mRt;
               cpuTypesPkg::fnAnd: e.aluResult = mRs & mRt;
               cpuTypesPkg::fnOr: e.aluResult = mRs | mRt;
               cpuTypesPkg::fnXor: e.aluResult = mRs ^ mRt;
               cpuTypesPkg::fnNor: e.aluResult = ~(mRs | mRt);
               cpuTypesPkg::fnSlt: e.aluResult = ($signed(mRs) < $signed(mRt)) ? 1 : 0;
               cpuTypesPkg::fnSltu: e.aluResult = (mRs < mRt) ? 1 : 0;
               cpuTypesPkg::fnSll: e.aluResult = mRt << mInstr.rType.shamt;
               default: e.aluResult = mRt >> mInstr.rType.shamt;
            endcase
         end
      end
      cpuTypesPkg::opAddiu: e.aluResult = mRs + sImm;
      cpuTypesPkg::opSlti: e.aluResult = ($signed(mRs) < $signed(sImm)) ? 1 : 0;
      cpuTypesPkg::opAndi: e.aluResult = mRs & zImm;
      cpuTypesPkg::opOri: e.aluResult = mRs | zImm;
      cpuTypesPkg::opXori: e.aluResult = mRs ^ zImm;
      cpuTypesPkg::opLui: e.aluResult = {mInstr.iType.imm, 16'h0000};
      cpuTypesPkg::opLw:
      begin
         e.aluResult = mRs + sImm;
         e.memRead = 1'b1;
         e.memToReg = 1'b1;
      end
      cpuTypesPkg::opSw:
      begin
         e.aluResult = mRs + sImm;
         e.memWrite = 1'b1;
      end
      cpuTypesPkg::opBeq,
      cpuTypesPkg::opBne:
      begin
         e.careAlu = 1'b0;
         e.careTarget = 1'b1;
         e.branchTarget = mPc + (sImm << 2);
         e.branchTaken = (op == cpuTypesPkg::opBeq) ? (mRs == mRt) : (mRs != mRt);
      end
      cpuTypesPkg::opJ,
      cpuTypesPkg::opJal:
      begin
         e.careTarget = 1'b1;
         e.branchTaken = 1'b1;
         e.branchTarget = {mPc[31:28], mInstr.jType.addr, 2'b00};
         if (op == cpuTypesPkg::opJal)
         begin
            // link register gets the return address
            e.aluResult = mPc;
            e.writeReg = 5'd31;
            e.regWen = 1'b1;
         end
         else
            e.careAlu = 1'b0;
      end
      default:
      begin
         e.halt = 1'b1;
         e.careAlu = 1'b0;
      end
   endcase
   return e;
endfunction

`endif

// File: dv/decodeExecuteTb.sv
`timescale 1ns/10ps

module decodeExecuteTb;

   logic CLK;
   logic nRST;
   cpuTypesPkg::instrWordT instr;
   logic [cpuTypesPkg::wordWidth-1:0] pcNext;
   logic advance;
   logic flush;
   logic wbWen;
   logic [cpuTypesPkg::regAddrWidth-1:0] wbReg;
   logic [cpuTypesPkg::wordWidth-1:0] wbData;
   logic [cpuTypesPkg::wordWidth-1:0] aluResult;
   logic [cpuTypesPkg::wordWidth-1:0] storeData;
   logic [cpuTypesPkg::wordWidth-1:0] branchTarget;
   logic [cpuTypesPkg::regAddrWidth-1:0] writeReg;
   logic regWen;
   logic memRead;
   logic memWrite;
   logic memToReg;
   logic halt;
   logic branchTaken;

   integer seed;
   int testErrors;
   int testsRun;
   int failedTests;

   `include "decodeExecuteModel.svh"

   decodeExecute decodeExecute_i
   (
      .CLK(CLK), .nRST(nRST), .instr(instr), .pcNext(pcNext),
      .advance(advance), .flush(flush),
      .wbWen(wbWen), .wbReg(wbReg), .wbData(wbData),
      .aluResult(aluResult), .storeData(storeData), .branchTarget(branchTarget),
      .writeReg(writeReg), .regWen(regWen), .memRead(memRead), .memWrite(memWrite),
      .memToReg(memToReg), .halt(halt), .branchTaken(branchTaken)
   );

   initial
      CLK = 1'b0;

   always #20 CLK = ~CLK;

   // index 0-9 R-type ALU, 10 JR, 11-18 I-type, 19-22 branch and jump, 23 HALT
   function automatic logic [11:0] instrCode(input int idx);
      case (idx)
         0: return {cpuTypesPkg::opRtype, cpuTypesPkg::fnAddu};
         1: return {cpuTypesPkg::opRtype, cpuTypesPkg::fnSubu};
         2: return {cpuTypesPkg::opRtype, cpuTypesPkg::fnAnd};
         3: return {cpuTypesPkg::opRtype, cpuTypesPkg::fnOr};
         4: return {cpuTypesPkg::opRtype, cpuTypesPkg::fnXor};
         5: return {cpuTypesPkg::opRtype, cpuTypesPkg::fnNor};
         6: return {cpuTypesPkg::opRtype, cpuTypesPkg::fnSlt};
         7: return {cpuTypesPkg::opRtype, cpuTypesPkg::fnSltu};
         8: return {cpuTypesPkg::opRtype, cpuTypesPkg::fnSll};
         9: return {cpuTypesPkg::opRtype, cpuTypesPkg::fnSrl};
         10: return {cpuTypesPkg::opRtype, cpuTypesPkg::fnJr};
         11: return {cpuTypesPkg::opAddiu, 6'h00};
         12: return {cpuTypesPkg::opAndi, 6'h00};
         13: return {cpuTypesPkg::opOri, 6'h00};
         14: return {cpuTypesPkg::opXori, 6'h00};
         15: return {cpuTypesPkg::opSlti, 6'h00};
         16: return {cpuTypesPkg::opLui, 6'h00};
         17: return {cpuTypesPkg::opLw, 6'h00};
         18: return {cpuTypesPkg::opSw, 6'h00};
         19: return {cpuTypesPkg::opBeq, 6'h00};
         20: return {cpuTypesPkg::opBne, 6'h00};
         21: return {cpuTypesPkg::opJ, 6'h00};
         22: return {cpuTypesPkg::opJal, 6'h00};
         default: return {cpuTypesPkg::opHalt, 6'h00};
      endcase
   endfunction

   // low registers are favoured so bypass and branch equality happen often
   task automatic pickReg(output logic [4:0] r);
      if (($random(seed) & 3) == 0)
         r = $random(seed);
      else
         r = $random(seed) & 7;
   endtask

   task automatic makeInstr(input int kind, output cpuTypesPkg::instrWordT w);
      int idx;
      logic [11:0] code;
      logic [4:0] r;
      case (kind)
         1: idx = $unsigned($random(seed)) % 10;
         2: idx = 11 + $unsigned($random(seed)) % 8;
         3:
         begin
            idx = $unsigned($random(seed)) % 5;
            idx = (idx == 0) ? 10 : 18 + idx;
         end
         default: idx = $unsigned($random(seed)) % 24;
      endcase
      code = instrCode(idx);
      w = $random(seed);
      w.rType.opcode = code[11:6];
      pickReg(r);
      w.rType.rs = r;
      pickReg(r);
      w.rType.rt = r;
      if (code[11:6] == cpuTypesPkg::opRtype)
      begin
         w.rType.funct = code[5:0];
         pickReg(r);
         w.rType.rd = r;
      end
      if (kind == 3 && ($random(seed) & 1))
         w.iType.rt = w.iType.rs;
   endtask

   task automatic driveInputs(input int kind, output logic seen);
      logic [5:0] op;
      makeInstr(kind, instr);
      op = instr.rType.opcode;
      pcNext = $random(seed);
      pcNext[1:0] = 2'b00;
      wbData = $random(seed);
      pickReg(wbReg);
      if ($random(seed) & 1)
         wbReg = ($random(seed) & 1) ? instr.rType.rs : instr.rType.rt;
      wbWen = (kind != 0) && (($random(seed) & 3) != 0);
      advance = (kind >= 1 && kind <= 3) ? 1'b1 : 1'b0;
      flush = ($random(seed) & 3) == 0;
      if (kind >= 4)
         advance = ($random(seed) & 3) != 0;
      else if (kind != 0)
         flush = 1'b0;
      case (kind)
         1: seen = wbWen && wbReg != 0 &&
                   (wbReg == instr.rType.rs || wbReg == instr.rType.rt);
         2: seen = op == cpuTypesPkg::opLw || op == cpuTypesPkg::opSw;
         3: seen = (op == cpuTypesPkg::opBeq || op == cpuTypesPkg::opBne) &&
                   readReg(instr.rType.rs, wbWen, wbReg, wbData) ==
                   readReg(instr.rType.rt, wbWen, wbReg, wbData);
         4: seen = advance && flush;
         default: seen = 1'b1;
      endcase
   endtask

   task automatic reportMismatch(input string name, input string signal,
                                 input logic [31:0] expected, input logic [31:0] actual);
      $display("mismatch %s %s: expected %h, actual %h", name, signal, expected, actual);
      testErrors++;
   endtask

   task automatic checkOutputs(input string name);
      expectT e;
      e = predict();
      if (e.careAlu && aluResult !== e.aluResult)
         reportMismatch(name, "aluResult", e.aluResult, aluResult);
      if (storeData !== e.storeData)
         reportMismatch(name, "storeData", e.storeData, storeData);
      if (e.careTarget && branchTarget !== e.branchTarget)
         reportMismatch(name, "branchTarget", e.branchTarget, branchTarget);
      if (writeReg !== e.writeReg)
         reportMismatch(name, "writeReg", e.writeReg, writeReg);
      if (regWen !== e.regWen)
         reportMismatch(name, "regWen", e.regWen, regWen);
      if (memRead !== e.memRead)
         reportMismatch(name, "memRead", e.memRead, memRead);
      if (memWrite !== e.memWrite)
         reportMismatch(name, "memWrite", e.memWrite, memWrite);
      if (memToReg !== e.memToReg)
         reportMismatch(name, "memToReg", e.memToReg, memToReg);
      if (halt !== e.halt)
         reportMismatch(name, "halt", e.halt, halt);
      if (branchTaken !== e.branchTaken)
         reportMismatch(name, "branchTaken", e.branchTaken, branchTaken);
   endtask

   // runs until enough events of the test's kind were seen or the cycle limit is hit
   task automatic runTest(input string name, input int kind, input int goal,
                          input int limit);
      int hits;
      int cycles;
      logic seen;
      hits = 0;
      cycles = 0;
      testErrors = 0;
      while (hits < goal && cycles < limit)
      begin
         driveInputs(kind, seen);
         if (seen)
            hits++;
         @(posedge CLK);
         stepModel(instr, pcNext, advance, flush, wbWen, wbReg, wbData);
         @(negedge CLK);
         checkOutputs(name);
         cycles++;
      end
      if (hits < goal)
      begin
         $display("test %s timed out after %0d cycles, saw only %0d of %0d events",
                  name, cycles, hits, goal);
         testErrors++;
      end
      testsRun++;
      if (testErrors != 0)
         failedTests++;
      $display("test %s finished after %0d cycles with %0d errors", name, cycles, testErrors);
   endtask

   initial
   begin
      seed = 33;
      nRST = 1'b0;
      instr = '0;
      pcNext = '0;
      advance = 1'b0;
      flush = 1'b0;
      wbWen = 1'b0;
      wbReg = '0;
      wbData = '0;
      testErrors = 0;
      testsRun = 0;
      failedTests = 0;
      resetModel();
      repeat (10) @(negedge CLK);
      nRST = 1'b1;

      // stalled right after reset, so the reset bubble must stay put
      runTest("reset", 0, 4, 10);
      runTest("rtypeAlu", 1, 40, 1000);
      runTest("itypeMem", 2, 60, 1000);
      runTest("branchJump", 3, 30, 1000);
      runTest("stallFlush", 4, 30, 1000);
      runTest("mixedRun", 5, 2000, 2100);

      $display("tests run %0d, passed %0d, failed %0d", testsRun, testsRun - failedTests,
               failedTests);
      if (failedTests == 0)
         $display("ALL TESTS PASSED");
      else
         $display("SOME TESTS FAILED");
      $finish;
   end

endmodule

// File: flist.f
+incdir+dv
design/cpuTypesPkg.sv
design/controlUnit.sv
design/registerFile.sv
design/idExRegister.sv
design/executeStage.sv
design/decodeExecute.sv
dv/decodeExecuteTb.sv
